// File: source/buffer_params.svh
`ifndef BUFFER_PARAMS_SVH
`define BUFFER_PARAMS_SVH

// parallel adc channels, one bank per channel
`define BUF_CHANNELS 4
// samples held by each bank
`define BUF_DEPTH 16
// bits per adc sample
`define BUF_DATA_WIDTH 16
// register stages behind the memory read port
`define BUF_READ_LATENCY 2

`endif

// File: source/sample_pkg.sv
`include "buffer_params.svh"

package sample_pkg;

  // one adc sample
  typedef logic [`BUF_DATA_WIDTH-1:0] sample_t;
  // one sample per channel, channel 0 in the low slot
  typedef sample_t [`BUF_CHANNELS-1:0] sample_vec_t;
  // one bit per channel or per bank
  typedef logic [`BUF_CHANNELS-1:0] chan_mask_t;
  // word address inside a bank
  typedef logic [$clog2(`BUF_DEPTH)-1:0] addr_t;
  typedef addr_t [`BUF_CHANNELS-1:0] addr_vec_t;
  // bank index
  typedef logic [$clog2(`BUF_CHANNELS)-1:0] bank_sel_t;

endpackage

// File: source/buffer_cfg_pkg.sv
`include "buffer_params.svh"

package buffer_cfg_pkg;

  // log2 of the number of active channels, 3 behaves like 2
  typedef logic [1:0] banking_mode_t;
  // active channel count, 1, 2 or 4
  typedef logic [2:0] active_count_t;

  // sample count of one bank, wide enough to hold a full bank
  typedef logic [$clog2(`BUF_DEPTH):0] depth_count_t;

  // status of one bank after a capture
  typedef struct packed {
    logic         full;
    depth_count_t count;
  } bank_depth_t;

  typedef bank_depth_t [`BUF_CHANNELS-1:0] depth_report_t;

endpackage

// File: source/capture_fsm.sv
`timescale 1ns/1ps

module capture_fsm (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic capture_arm_valid,
  input  logic capture_arm_data,
  input  logic adc_capture_hw_start,
  input  logic adc_capture_hw_stop,
  input  logic capture_full,
  input  logic full_now,
  input  logic readout_done,
  output logic capture_start,
  output logic capture_active,
  output logic capture_done,
  output logic capture_idle,
  output logic adc_capture_ready
);

  typedef enum logic [1:0] {st_idle, st_trigger_wait, st_save, st_hold} capture_state_t;

  capture_state_t state;
  logic arm_accept;
  logic stop_pulse;
  logic capture_full_q;

  // arm only counts when its data bit is set
  assign adc_capture_ready = (state != st_hold);
  assign capture_idle = (state == st_idle);
  assign arm_accept = capture_arm_valid & adc_capture_ready & capture_arm_data;

  // triggers only matter in their own state
  assign capture_start = (state == st_trigger_wait) & adc_capture_hw_start;
  assign stop_pulse = (state == st_save) & adc_capture_hw_stop;
  // end of capture on stop, or on the first cycle the buffer reports full
  assign capture_done = stop_pulse | ((state == st_save) & capture_full & ~capture_full_q);

  ////////////////////////////////////////////////////////////////////////////
  // capture-active flag
  ////////////////////////////////////////////////////////////////////////////

  // set by start, cleared by stop or by the write that fills the last bank
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      capture_active <= 1'b0;
      capture_full_q <= 1'b0;
    end else begin
      capture_full_q <= capture_full;
      if (capture_start) begin
        capture_active <= 1'b1;
      end else if (stop_pulse | full_now) begin
        capture_active <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state transitions
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state <= st_idle;
    end else begin
      unique case (state)
        st_idle: begin
          if (arm_accept) begin
            state <= st_trigger_wait;
          end
        end
        st_trigger_wait: begin
          if (capture_start) begin
            state <= st_save;
          end
        end
        st_save: begin
          // samples stay put until the readout drains them
          if (stop_pulse | capture_full) begin
            state <= st_hold;
          end
        end
        st_hold: begin
          if (readout_done) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: source/bank_writer.sv
`timescale 1ns/1ps
`include "buffer_params.svh"

module bank_writer import sample_pkg::*, buffer_cfg_pkg::*; (
  input  logic          adc_clk,
  input  logic          adc_reset,
  input  sample_vec_t   adc_data,
  input  chan_mask_t    adc_valid,
  input  logic          banking_mode_valid,
  input  banking_mode_t banking_mode_data,
  input  logic          capture_idle,
  input  logic          capture_start,
  input  logic          capture_active,
  input  logic          capture_done,
  input  logic          readout_done,
  output chan_mask_t    wr_en,
  output addr_vec_t     wr_addr,
  output sample_vec_t   wr_data,
  output logic          capture_full,
  output logic          full_now,
  output depth_report_t depth_report,
  output logic          depth_report_valid,
  output logic          banking_mode_ready
);

  active_count_t active_count;
  banking_mode_t mode_clamped;
  sample_vec_t   data_q;
  chan_mask_t    valid_q;
  chan_mask_t    full_mask;
  chan_mask_t    valid_mask;
  chan_mask_t    write_enable;
  chan_mask_t    bank_full;
  chan_mask_t    full_latch;
  addr_vec_t     write_addr;

  ////////////////////////////////////////////////////////////////////////////
  // banking mode
  ////////////////////////////////////////////////////////////////////////////

  // mode may only change between captures
  assign banking_mode_ready = capture_idle;
  assign mode_clamped = (banking_mode_data > banking_mode_t'($clog2(`BUF_CHANNELS))) ?
                        banking_mode_t'($clog2(`BUF_CHANNELS)) : banking_mode_data;

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      active_count <= active_count_t'(`BUF_CHANNELS);
    end else if (banking_mode_valid & banking_mode_ready) begin
      active_count <= active_count_t'(1) << mode_clamped;
    end
  end

  // full mask covers the top active_count banks, the last link of each chain
  // valid mask starts on the low banks and hops up by active_count per fill
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      full_mask <= '0;
      valid_mask <= '0;
    end else begin
      for (int c = 0; c < `BUF_CHANNELS; c++) begin
        full_mask[`BUF_CHANNELS-1-c] <= (c < int'(active_count));
        if (capture_start) begin
          valid_mask[c] <= (c < int'(active_count));
        end else if (bank_full[c]) begin
          valid_mask[c] <= 1'b0;
          if (c + int'(active_count) < `BUF_CHANNELS) begin
            valid_mask[c + int'(active_count)] <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // input registers and channel mux
  ////////////////////////////////////////////////////////////////////////////

  // bank c takes channel c modulo the active count
  always_ff @(posedge adc_clk) begin
    data_q <= adc_data;
    for (int c = 0; c < `BUF_CHANNELS; c++) begin
      wr_data[c] <= data_q[bank_sel_t'(c % int'(active_count))];
    end
    wr_addr <= write_addr;
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_q <= '0;
      wr_en <= '0;
    end else begin
      valid_q <= adc_valid;
      wr_en <= write_enable;
    end
  end

  // write enables and per-bank fill detect
  always_comb begin
    for (int c = 0; c < `BUF_CHANNELS; c++) begin
      write_enable[c] = capture_active & valid_mask[c]
                        & valid_q[bank_sel_t'(c % int'(active_count))];
      bank_full[c] = write_enable[c] & (write_addr[c] == addr_t'(`BUF_DEPTH - 1));
    end
  end

  assign full_now = |(bank_full & full_mask);
  assign capture_full = |(full_latch & full_mask);

  ////////////////////////////////////////////////////////////////////////////
  // write addresses, full flags, depth report
  ////////////////////////////////////////////////////////////////////////////

  // a finished readout frees every bank
  always_ff @(posedge adc_clk) begin
    if (adc_reset || readout_done) begin
      write_addr <= '0;
      full_latch <= '0;
    end else begin
      for (int c = 0; c < `BUF_CHANNELS; c++) begin
        if (write_enable[c]) begin
          write_addr[c] <= write_addr[c] + addr_t'(1);
        end
        if (bank_full[c]) begin
          full_latch[c] <= 1'b1;
        end
      end
    end
  end

  // report counts the write that may still land in the done cycle
  always_ff @(posedge adc_clk) begin
    if (capture_done) begin
      for (int c = 0; c < `BUF_CHANNELS; c++) begin
        depth_report[c].full <= full_latch[c] | bank_full[c];
        depth_report[c].count <= full_latch[c] ? depth_count_t'(`BUF_DEPTH) :
                                 {1'b0, write_addr[c]} + depth_count_t'(write_enable[c]);
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      depth_report_valid <= 1'b0;
    end else begin
      depth_report_valid <= capture_done;
    end
  end

endmodule

// File: source/sample_memory.sv
`timescale 1ns/1ps
`include "buffer_params.svh"

module sample_memory import sample_pkg::*; (
  input  logic        adc_clk,
  input  chan_mask_t  wr_en,
  input  addr_vec_t   wr_addr,
  input  sample_vec_t wr_data,
  input  logic        rd_en,
  input  addr_t       rd_addr,
  input  bank_sel_t   rd_bank,
  output sample_t     rd_data
);

  sample_t mem [`BUF_CHANNELS][`BUF_DEPTH];
  sample_t rd_pipe [`BUF_CHANNELS][`BUF_READ_LATENCY];

  // each bank has its own write address
  always_ff @(posedge adc_clk) begin
    for (int b = 0; b < `BUF_CHANNELS; b++) begin
      if (wr_en[b]) begin
        mem[b][wr_addr[b]] <= wr_data[b];
      end
    end
  end

  // all banks read in parallel, whole pipe holds when rd_en is low
  always_ff @(posedge adc_clk) begin
    if (rd_en) begin
      for (int b = 0; b < `BUF_CHANNELS; b++) begin
        rd_pipe[b][0] <= mem[b][rd_addr];
        for (int s = 1; s < `BUF_READ_LATENCY; s++) begin
          rd_pipe[b][s] <= rd_pipe[b][s-1];
        end
      end
    end
  end

  // rd_bank arrives already delayed to line up with the last stage
  assign rd_data = rd_pipe[rd_bank][`BUF_READ_LATENCY-1];

endmodule

// File: source/readout_engine.sv
`timescale 1ns/1ps
`include "buffer_params.svh"

module readout_engine import sample_pkg::*; (
  input  logic      adc_clk,
  input  logic      adc_reset,
  input  logic      capture_done,
  input  logic      readout_start_valid,
  input  logic      readout_ready,
  input  sample_t   rd_data,
  output logic      readout_start_ready,
  output logic      rd_en,
  output addr_t     rd_addr,
  output bank_sel_t rd_bank,
  output sample_t   readout_data,
  output logic      readout_valid,
  output logic      readout_last,
  output logic      readout_done
);

  typedef enum logic [1:0] {st_idle, st_ready, st_active} readout_state_t;

  readout_state_t state;
  logic start_accept;
  logic issue;
  logic step;
  logic issue_last;
  bank_sel_t bank_cnt;
  logic [`BUF_READ_LATENCY-1:0] valid_pipe;
  logic [`BUF_READ_LATENCY-1:0] last_pipe;
  bank_sel_t [`BUF_READ_LATENCY-1:0] bank_pipe;

  assign readout_start_ready = (state == st_ready);
  assign start_accept = readout_start_valid & readout_start_ready;
  // pipeline moves unless a valid word is waiting on the sink
  assign rd_en = readout_ready | ~readout_valid;
  assign step = issue & rd_en;
  assign issue_last = (rd_addr == addr_t'(`BUF_DEPTH - 1))
                      & (bank_cnt == bank_sel_t'(`BUF_CHANNELS - 1));
  assign rd_bank = bank_pipe[`BUF_READ_LATENCY-1];
  assign readout_done = readout_valid & readout_ready & readout_last;

  ////////////////////////////////////////////////////////////////////////////
  // state and address sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state <= st_idle;
    end else begin
      unique case (state)
        st_idle:   if (capture_done) state <= st_ready;
        st_ready:  if (start_accept) state <= st_active;
        st_active: if (readout_done) state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

  // bank 0 words 0..15 first, then the next bank
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      issue <= 1'b0;
      rd_addr <= '0;
      bank_cnt <= '0;
    end else if (start_accept) begin
      issue <= 1'b1;
      rd_addr <= '0;
      bank_cnt <= '0;
    end else if (step) begin
      if (issue_last) begin
        issue <= 1'b0;
      end
      if (rd_addr == addr_t'(`BUF_DEPTH - 1)) begin
        rd_addr <= '0;
        bank_cnt <= bank_cnt + bank_sel_t'(1);
      end else begin
        rd_addr <= rd_addr + addr_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // valid, last and bank pipes matched to memory latency
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_pipe <= '0;
      last_pipe <= '0;
      readout_valid <= 1'b0;
      readout_last <= 1'b0;
    end else if (rd_en) begin
      valid_pipe[0] <= issue;
      last_pipe[0] <= issue & issue_last;
      for (int s = 1; s < `BUF_READ_LATENCY; s++) begin
        valid_pipe[s] <= valid_pipe[s-1];
        last_pipe[s] <= last_pipe[s-1];
      end
      readout_valid <= valid_pipe[`BUF_READ_LATENCY-1];
      readout_last <= last_pipe[`BUF_READ_LATENCY-1];
    end
  end

  // output word holds while stalled
  always_ff @(posedge adc_clk) begin
    if (rd_en) begin
      bank_pipe[0] <= bank_cnt;
      for (int s = 1; s < `BUF_READ_LATENCY; s++) begin
        bank_pipe[s] <= bank_pipe[s-1];
      end
      readout_data <= rd_data;
    end
  end

endmodule

// File: source/sample_buffer.sv
`timescale 1ns/1ps

module sample_buffer import sample_pkg::*, buffer_cfg_pkg::*; (
  input  logic          adc_clk,
  input  logic          adc_reset,
  // adc samples, never stalled
  input  sample_vec_t   adc_data,
  input  chan_mask_t    adc_valid,
  // realtime triggers and status
  input  logic          adc_capture_hw_start,
  input  logic          adc_capture_hw_stop,
  output logic          adc_capture_ready,
  output logic          adc_capture_full,
  // commands
  input  logic          capture_arm_valid,
  input  logic          capture_arm_data,
  output logic          capture_arm_ready,
  input  logic          banking_mode_valid,
  input  banking_mode_t banking_mode_data,
  output logic          banking_mode_ready,
  input  logic          readout_start_valid,
  output logic          readout_start_ready,
  // per-bank depth after each capture
  output depth_report_t depth_report,
  output logic          depth_report_valid,
  // readout stream
  output sample_t       readout_data,
  output logic          readout_valid,
  output logic          readout_last,
  input  logic          readout_ready
);

  logic capture_start;
  logic capture_active;
  logic capture_done;
  logic capture_idle;
  logic full_now;
  logic readout_done;
  chan_mask_t wr_en;
  addr_vec_t wr_addr;
  sample_vec_t wr_data;
  logic rd_en;
  addr_t rd_addr;
  bank_sel_t rd_bank;
  sample_t rd_data;

  // arm is taken whenever samples are not being held
  assign capture_arm_ready = adc_capture_ready;

  capture_fsm capture_fsm_i (
    .adc_clk              (adc_clk),
    .adc_reset            (adc_reset),
    .capture_arm_valid    (capture_arm_valid),
    .capture_arm_data     (capture_arm_data),
    .adc_capture_hw_start (adc_capture_hw_start),
    .adc_capture_hw_stop  (adc_capture_hw_stop),
    .capture_full         (adc_capture_full),
    .full_now             (full_now),
    .readout_done         (readout_done),
    .capture_start        (capture_start),
    .capture_active       (capture_active),
    .capture_done         (capture_done),
    .capture_idle         (capture_idle),
    .adc_capture_ready    (adc_capture_ready)
  );

  bank_writer bank_writer_i (
    .adc_clk            (adc_clk),
    .adc_reset          (adc_reset),
    .adc_data           (adc_data),
    .adc_valid          (adc_valid),
    .banking_mode_valid (banking_mode_valid),
    .banking_mode_data  (banking_mode_data),
    .capture_idle       (capture_idle),
    .capture_start      (capture_start),
    .capture_active     (capture_active),
    .capture_done       (capture_done),
    .readout_done       (readout_done),
    .wr_en              (wr_en),
    .wr_addr            (wr_addr),
    .wr_data            (wr_data),
    .capture_full       (adc_capture_full),
    .full_now           (full_now),
    .depth_report       (depth_report),
    .depth_report_valid (depth_report_valid),
    .banking_mode_ready (banking_mode_ready)
  );

  sample_memory sample_memory_i (
    .adc_clk (adc_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_bank (rd_bank),
    .rd_data (rd_data)
  );

  readout_engine readout_engine_i (
    .adc_clk             (adc_clk),
    .adc_reset           (adc_reset),
    .capture_done        (capture_done),
    .readout_start_valid (readout_start_valid),
    .readout_ready       (readout_ready),
    .rd_data             (rd_data),
    .readout_start_ready (readout_start_ready),
    .rd_en               (rd_en),
    .rd_addr             (rd_addr),
    .rd_bank             (rd_bank),
    .readout_data        (readout_data),
    .readout_valid       (readout_valid),
    .readout_last        (readout_last),
    .readout_done        (readout_done)
  );

endmodule

// File: tests/sample_buffer_assertions.sv
`timescale 1ns/1ps

module sample_buffer_assertions import sample_pkg::*; (
  input logic    adc_clk,
  input logic    adc_reset,
  input sample_t readout_data,
  input logic    readout_valid,
  input logic    readout_last,
  input logic    readout_ready,
  input logic    depth_report_valid
);

  // number of assertion failures so far
  int failures = 0;

  // a stalled word keeps its data and last marker
  stall_hold: assert property (@(posedge adc_clk) disable iff (adc_reset)
    readout_valid && !readout_ready |=>
      readout_valid && $stable(readout_data) && $stable(readout_last))
  else begin
    $error("readout word changed while stalled");
    failures++;
  end

  // report strobe is a single cycle
  report_pulse: assert property (@(posedge adc_clk) disable iff (adc_reset)
    depth_report_valid |=> !depth_report_valid)
  else begin
    $error("depth report valid held longer than one cycle");
    failures++;
  end

  last_with_valid: assert property (@(posedge adc_clk) disable iff (adc_reset)
    readout_last |-> readout_valid)
  else begin
    $error("readout last without readout valid");
    failures++;
  end

endmodule

bind sample_buffer sample_buffer_assertions protocol_checks (
  .adc_clk            (adc_clk),
  .adc_reset          (adc_reset),
  .readout_data       (readout_data),
  .readout_valid      (readout_valid),
  .readout_last       (readout_last),
  .readout_ready      (readout_ready),
  .depth_report_valid (depth_report_valid)
);

// File: tests/sample_buffer_tb.sv
`timescale 1ns/1ps
`include "buffer_params.svh"

module sample_buffer_tb import sample_pkg::*, buffer_cfg_pkg::*; ();

  localparam int words = `BUF_CHANNELS * `BUF_DEPTH;
  localparam int max_stall = 4;
  localparam int capture_cycles = 256;
  localparam int wait_limit = 64;
  localparam int num_tests = 5;
  // one capture plus one fully throttled readout per test, with handshake slack
  localparam int watchdog_cycles =
    num_tests * (capture_cycles + words * (max_stall + 1) + 4 * wait_limit);

  typedef enum {wait_arm, wait_mode, wait_start, wait_report} wait_sel_t;

  logic          adc_clk;
  logic          adc_reset;
  sample_vec_t   adc_data;
  chan_mask_t    adc_valid;
  logic          adc_capture_hw_start;
  logic          adc_capture_hw_stop;
  logic          adc_capture_ready;
  logic          adc_capture_full;
  logic          capture_arm_valid;
  logic          capture_arm_data;
  logic          capture_arm_ready;
  logic          banking_mode_valid;
  banking_mode_t banking_mode_data;
  logic          banking_mode_ready;
  logic          readout_start_valid;
  logic          readout_start_ready;
  depth_report_t depth_report;
  logic          depth_report_valid;
  sample_t       readout_data;
  logic          readout_valid;
  logic          readout_last;
  logic          readout_ready;

  // reference model, one queue of stored samples per bank
  integer        seed;
  active_count_t model_active;
  sample_t       bank_q [`BUF_CHANNELS][$];
  int            chan_count [`BUF_CHANNELS];
  logic          model_full;
  logic          in_window;

  sample_buffer uut (.*);

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge adc_clk);
    stop_with_failure("watchdog expired before the tests finished");
  end

  // a bound protocol assertion that fires ends the run at once
  initial begin
    wait (uut.protocol_checks.failures != 0);
    stop_with_failure("a protocol assertion on the readout or report outputs failed");
  end

  //////////////////////////////////////////////////////////////////////////////
  // failure reporting and compare tasks
  //////////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_report(input depth_report_t got, input depth_report_t exp);
    for (int b = 0; b < `BUF_CHANNELS; b++) begin
      if (got[b] !== exp[b]) begin
        stop_with_failure($sformatf(
          "Fail at %0t: bank %0d report full %b count %0d, expected %b %0d",
          $time, b, got[b].full, got[b].count, exp[b].full, exp[b].count));
      end
    end
  endtask

  // data is skipped for words that this capture never wrote
  task automatic check_word(input int index, input sample_t got, input logic got_last,
                            input sample_t exp, input logic exp_last, input bit known);
    if (known && got !== exp) begin
      stop_with_failure($sformatf("Fail at %0t: word %0d data %h, expected %h",
                                  $time, index, got, exp));
    end
    if (got_last !== exp_last) begin
      stop_with_failure($sformatf("Fail at %0t: word %0d last %b, expected %b",
                                  $time, index, got_last, exp_last));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////////////

  // channel c chains through banks c, c+A, c+2A... until its last bank fills
  function automatic void record_sample(input sample_vec_t d, input chan_mask_t v);
    int bank;
    if (!model_full) begin
      for (int c = 0; c < int'(model_active); c++) begin
        if (v[c]) begin
          bank = c + int'(model_active) * (chan_count[c] / `BUF_DEPTH);
          bank_q[bank].push_back(d[c]);
          chan_count[c]++;
          if (chan_count[c] == `BUF_DEPTH * `BUF_CHANNELS / int'(model_active)) begin
            model_full = 1'b1;
          end
        end
      end
    end
  endfunction

  function automatic depth_report_t expected_report();
    depth_report_t r;
    for (int b = 0; b < `BUF_CHANNELS; b++) begin
      r[b].count = depth_count_t'(bank_q[b].size());
      r[b].full = (bank_q[b].size() == `BUF_DEPTH);
    end
    return r;
  endfunction

  function automatic void clear_model();
    for (int b = 0; b < `BUF_CHANNELS; b++) begin
      bank_q[b].delete();
      chan_count[b] = 0;
    end
    model_full = 1'b0;
  endfunction

  //////////////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////////////

  function automatic logic probe(input wait_sel_t sel);
    case (sel)
      wait_arm:   return capture_arm_ready;
      wait_mode:  return banking_mode_ready;
      wait_start: return readout_start_ready;
      default:    return depth_report_valid;
    endcase
  endfunction

  // returns 1 ns after the edge where the signal was seen high
  task automatic wait_high(input wait_sel_t sel, input string what);
    int cycles;
    cycles = 0;
    do begin
      @(posedge adc_clk);
      cycles++;
      if (cycles > wait_limit) begin
        stop_with_failure({"timed out waiting for ", what});
      end
    end while (!probe(sel));
    #1;
  endtask

  // one cycle of random samples, logged when inside the capture window
  task automatic drive_sample(input chan_mask_t en);
    sample_vec_t d;
    chan_mask_t v;
    for (int c = 0; c < `BUF_CHANNELS; c++) begin
      d[c] = sample_t'($random(seed));
    end
    v = chan_mask_t'($random(seed)) & en;
    adc_data = d;
    adc_valid = v;
    if (in_window) begin
      record_sample(d, v);
    end
    @(posedge adc_clk);
    #1;
  endtask

  task automatic set_mode(input banking_mode_t mode);
    banking_mode_valid = 1'b1;
    banking_mode_data = mode;
    wait_high(wait_mode, "banking mode ready");
    banking_mode_valid = 1'b0;
    // 3 has no wider setting, it acts as four channels
    model_active = active_count_t'(1) << ((mode > 2'd2) ? 2'd2 : mode);
  endtask

  // length counts the stored window, start cycle included
  task automatic run_capture(input int length, input chan_mask_t en, input bit to_full);
    int cycles;
    capture_arm_valid = 1'b1;
    capture_arm_data = 1'b1;
    wait_high(wait_arm, "capture arm ready");
    capture_arm_valid = 1'b0;
    drive_sample(en);
    check_flag("readout start ready before report", readout_start_ready, 1'b0);
    adc_capture_hw_start = 1'b1;
    in_window = 1'b1;
    drive_sample(en);
    adc_capture_hw_start = 1'b0;
    check_flag("banking mode ready in save", banking_mode_ready, 1'b0);
    if (to_full) begin
      cycles = 0;
      while (!adc_capture_full) begin
        drive_sample(en);
        cycles++;
        if (cycles > capture_cycles) begin
          stop_with_failure("buffer never reported full");
        end
      end
      check_flag("model full", model_full, 1'b1);
    end else begin
      repeat (length - 1) drive_sample(en);
      in_window = 1'b0;
      adc_capture_hw_stop = 1'b1;
      drive_sample(en);
      adc_capture_hw_stop = 1'b0;
    end
    in_window = 1'b0;
    wait_high(wait_report, "depth report");
    check_report(depth_report, expected_report());
    // commands in hold must bounce off
    check_flag("arm ready in hold", capture_arm_ready, 1'b0);
    check_flag("banking mode ready in hold", banking_mode_ready, 1'b0);
    check_flag("readout start ready after report", readout_start_ready, 1'b1);
    banking_mode_valid = 1'b1;
    banking_mode_data = 2'd0;
    @(posedge adc_clk);
    #1;
    banking_mode_valid = 1'b0;
  endtask

  // bank 0 words first, stalls capped at max_stall when throttled
  task automatic run_readout(input bit throttle);
    int n;
    int cycles;
    int stall;
    int bank;
    int addr;
    bit known;
    readout_start_valid = 1'b1;
    wait_high(wait_start, "readout start ready");
    readout_start_valid = 1'b0;
    readout_ready = 1'b1;
    n = 0;
    cycles = 0;
    stall = 0;
    while (n < words) begin
      @(posedge adc_clk);
      if (readout_valid && readout_ready) begin
        bank = n / `BUF_DEPTH;
        addr = n % `BUF_DEPTH;
        known = (addr < bank_q[bank].size());
        check_word(n, readout_data, readout_last, known ? bank_q[bank][addr] : '0,
                   (n == words - 1), known);
        n++;
      end
      cycles++;
      if (cycles > words * (max_stall + 1) + wait_limit) begin
        stop_with_failure("readout stream stopped before the last word");
      end
      #1;
      if (throttle) begin
        readout_ready = (stall >= max_stall) ? 1'b1 : 1'($random(seed));
        stall = readout_ready ? 0 : stall + 1;
      end
    end
    readout_ready = 1'b1;
    // buffer re-opens and no extra word follows the last
    check_flag("readout valid after last", readout_valid, 1'b0);
    check_flag("capture ready after readout", adc_capture_ready, 1'b1);
    check_flag("capture full after readout", adc_capture_full, 1'b0);
    clear_model();
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////////////

  initial begin
    seed = 32'hd68b_761a;
    adc_reset = 1'b1;
    adc_data = '0;
    adc_valid = '0;
    adc_capture_hw_start = 1'b0;
    adc_capture_hw_stop = 1'b0;
    capture_arm_valid = 1'b0;
    capture_arm_data = 1'b0;
    banking_mode_valid = 1'b0;
    banking_mode_data = '0;
    readout_start_valid = 1'b0;
    readout_ready = 1'b0;
    model_active = active_count_t'(`BUF_CHANNELS);
    in_window = 1'b0;
    clear_model();
    repeat (3) @(posedge adc_clk);
    #1;
    adc_reset = 1'b0;
    check_flag("capture full after reset", adc_capture_full, 1'b0);
    check_flag("report valid after reset", depth_report_valid, 1'b0);
    check_flag("readout valid after reset", readout_valid, 1'b0);
    check_flag("readout last after reset", readout_last, 1'b0);
    check_flag("capture ready after reset", adc_capture_ready, 1'b1);
    check_flag("banking mode ready after reset", banking_mode_ready, 1'b1);
    check_flag("readout start ready after reset", readout_start_ready, 1'b0);

    // one channel runs through all four banks, fills every word first
    set_mode(2'd0);
    run_capture(0, '1, 1'b1);
    run_readout(1'b0);

    // four channels, short window ended by hw_stop
    set_mode(2'd2);
    run_capture(1 + {$random(seed)} % 15, '1, 1'b0);
    run_readout(1'b0);

    // two channels, bank 0 chains into 2 and bank 1 into 3
    set_mode(2'd1);
    run_capture(16 + {$random(seed)} % 16, '1, 1'b0);
    run_readout(1'b0);

    // two channels to full, then readout under random back-pressure
    run_capture(0, '1, 1'b1);
    run_readout(1'b1);

    // hw_start ahead of arm is ignored, mode 3 acts as four channels
    set_mode(2'd3);
    adc_capture_hw_start = 1'b1;
    repeat (3) drive_sample('1);
    adc_capture_hw_start = 1'b0;
    run_capture(1 + {$random(seed)} % 15, '1, 1'b0);
    run_readout(1'b1);

    @(posedge adc_clk);
    if (uut.protocol_checks.failures == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+source
source/sample_pkg.sv
source/buffer_cfg_pkg.sv
source/capture_fsm.sv
source/bank_writer.sv
source/sample_memory.sv
source/readout_engine.sv
source/sample_buffer.sv
tests/sample_buffer_assertions.sv
tests/sample_buffer_tb.sv

// File: Bender.yml
package:
  name: sample_buffer

export_include_dirs:
  - source

sources:
  - files:
      - source/sample_pkg.sv
      - source/buffer_cfg_pkg.sv
      - source/capture_fsm.sv
      - source/bank_writer.sv
      - source/sample_memory.sv
      - source/readout_engine.sv
      - source/sample_buffer.sv
  - target: test
    files:
      - tests/sample_buffer_assertions.sv
      - tests/sample_buffer_tb.sv
